/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // datapath widths
    localparam int XLEN = 64;
    localparam int WLEN = 32;   // word ops

    typedef logic [XLEN-1:0] xlen_t;      // operand, result, address
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [7:0]      wmask_t;     // one bit per byte lane

    // major opcodes
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_IMM_32 = 7'b0011011;
    localparam opcode_t OP        = 7'b0110011;
    localparam opcode_t OP_32     = 7'b0111011;
    localparam opcode_t BRANCH    = 7'b1100011;
    localparam opcode_t LOAD      = 7'b0000011;
    localparam opcode_t STORE     = 7'b0100011;
    localparam opcode_t JAL       = 7'b1101111;
    localparam opcode_t JALR      = 7'b1100111;
    localparam opcode_t LUI       = 7'b0110111;
    localparam opcode_t AUIPC     = 7'b0010111;

    // alu groups, shared by OP, OP_IMM and the word forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;   // srl and sra
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load sizes, bit 2 marks the unsigned forms
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;

    // store sizes
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SD = 3'b011;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;   // sub, sra

endpackage

/* ex_pkg.sv */
package ex_pkg;

    // alu operation codes
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLL   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_SLT   = 4'd8;
    localparam alu_op_t ALU_SLTU  = 4'd9;
    localparam alu_op_t ALU_PASS2 = 4'd10;  // lui

    // operands as prepared by decode
    typedef struct packed {
        rv_isa_pkg::inst_t     inst;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::xlen_t     op1;
        rv_isa_pkg::xlen_t     op2;
        rv_isa_pkg::reg_addr_t rd_addr;
        rv_isa_pkg::xlen_t     base_addr;    // branch, jump and memory base
        rv_isa_pkg::xlen_t     offset_addr;
    } ex_req_t;

    typedef struct packed {
        alu_op_t             alu_op;
        logic                word_op;    // 32-bit op, sign-extended
        logic                is_branch;
        logic                is_jump;
        logic                is_load;
        logic                is_store;
        logic                rd_wen;
        rv_isa_pkg::funct3_t mem_size;
    } dec_t;

    typedef struct packed {
        logic                  wen;
        rv_isa_pkg::reg_addr_t waddr;
        rv_isa_pkg::xlen_t     wdata;
    } wb_t;

    typedef struct packed {
        logic                ren;
        logic                wen;
        rv_isa_pkg::xlen_t   addr;
        rv_isa_pkg::xlen_t   wdata;
        rv_isa_pkg::wmask_t  wmask;
        rv_isa_pkg::funct3_t size;   // load extension done in mem stage
    } mem_req_t;

    typedef struct packed {
        logic              en;
        rv_isa_pkg::xlen_t addr;
    } jump_t;

endpackage

/* ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
    input  rv_isa_pkg::inst_t inst_i,
    output ex_pkg::dec_t      dec_o
);
    import rv_isa_pkg::*;
    import ex_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    alt;      // inst[30], picks sub / sra
    logic    f7_ok;    // func7 legal for register-register ops

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = inst_i[30];

    // alt only allowed on add/sub and the right shifts
    assign f7_ok = (funct7 == F7_BASE) ||
                   ((funct7 == F7_ALT) && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SR)));

    function automatic alu_op_t alu_sel(input funct3_t f3, input logic sub_sra);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_o = '0;   // unknown encodings fall out with every enable low
        case (opcode)
            OP_IMM: begin
                dec_o.alu_op = alu_sel(funct3, (funct3 == F3_SR) && alt); // no subi
                dec_o.rd_wen = 1'b1;
            end
            OP_IMM_32: begin
                if (funct3 == F3_ADD_SUB || funct3 == F3_SLL || funct3 == F3_SR) begin
                    dec_o.alu_op  = alu_sel(funct3, (funct3 == F3_SR) && alt);
                    dec_o.word_op = 1'b1;
                    dec_o.rd_wen  = 1'b1;
                end
            end
            OP: begin
                if (f7_ok) begin
                    dec_o.alu_op = alu_sel(funct3, alt);
                    dec_o.rd_wen = 1'b1;
                end
            end
            OP_32: begin
                if (f7_ok && (funct3 == F3_ADD_SUB || funct3 == F3_SLL || funct3 == F3_SR)) begin
                    dec_o.alu_op  = alu_sel(funct3, alt);
                    dec_o.word_op = 1'b1;
                    dec_o.rd_wen  = 1'b1;
                end
            end
            BRANCH: dec_o.is_branch = 1'b1;   // condition resolved in addr unit
            LOAD: begin
                if (funct3 != 3'b111) begin
                    dec_o.is_load  = 1'b1;
                    dec_o.rd_wen   = 1'b1;
                    dec_o.mem_size = funct3;
                end
            end
            STORE: begin
                if (funct3[2] == 1'b0) begin   // sb .. sd only
                    dec_o.is_store = 1'b1;
                    dec_o.mem_size = funct3;
                end
            end
            JAL, JALR: begin
                dec_o.alu_op  = ALU_ADD;   // link value op1 + op2
                dec_o.is_jump = 1'b1;
                dec_o.rd_wen  = 1'b1;
            end
            LUI: begin
                dec_o.alu_op = ALU_PASS2;
                dec_o.rd_wen = 1'b1;
            end
            AUIPC: begin
                dec_o.alu_op = ALU_ADD;
                dec_o.rd_wen = 1'b1;
            end
            default: dec_o = '0;
        endcase
    end

endmodule

/* ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  rv_isa_pkg::xlen_t op1_i,
    input  rv_isa_pkg::xlen_t op2_i,
    input  ex_pkg::alu_op_t   alu_op_i,
    input  logic              word_op_i,
    output rv_isa_pkg::xlen_t result_o,
    output logic              eq_o,
    output logic              lt_o,
    output logic              ltu_o
);
    import rv_isa_pkg::*;
    import ex_pkg::*;

    logic [5:0]      shamt;
    logic [4:0]      shamt_w;   // word shifts ignore op2[5]
    logic [WLEN-1:0] op1_w;
    logic [WLEN-1:0] op2_w;
    xlen_t           res_d;
    logic [WLEN-1:0] res_w;

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];
    assign op1_w   = op1_i[WLEN-1:0];
    assign op2_w   = op2_i[WLEN-1:0];

    // flags always on the full width
    assign eq_o  = (op1_i == op2_i);
    assign lt_o  = ($signed(op1_i) < $signed(op2_i));
    assign ltu_o = (op1_i < op2_i);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   res_d = op1_i + op2_i;
            ALU_SUB:   res_d = op1_i - op2_i;
            ALU_AND:   res_d = op1_i & op2_i;
            ALU_OR:    res_d = op1_i | op2_i;
            ALU_XOR:   res_d = op1_i ^ op2_i;
            ALU_SLL:   res_d = op1_i << shamt;
            ALU_SRL:   res_d = op1_i >> shamt;
            ALU_SRA:   res_d = $signed(op1_i) >>> shamt;
            ALU_SLT:   res_d = {{(XLEN-1){1'b0}}, lt_o};
            ALU_SLTU:  res_d = {{(XLEN-1){1'b0}}, ltu_o};
            ALU_PASS2: res_d = op2_i;
            default:   res_d = '0;
        endcase
    end

    // only the shifts differ from the low half above
    always_comb begin
        case (alu_op_i)
            ALU_SLL: res_w = op1_w << shamt_w;
            ALU_SRL: res_w = op1_w >> shamt_w;
            ALU_SRA: res_w = $signed(op1_w) >>> shamt_w;   // sign from bit 31
            default: res_w = res_d[WLEN-1:0];
        endcase
    end

    assign result_o = word_op_i ? {{(XLEN-WLEN){res_w[WLEN-1]}}, res_w} : res_d;

endmodule

/* ex_addr_unit.sv */
`timescale 1ns/1ps

module ex_addr_unit (
    input  ex_pkg::ex_req_t  req_i,
    input  ex_pkg::dec_t     dec_i,
    input  logic             eq_i,
    input  logic             lt_i,
    input  logic             ltu_i,
    output ex_pkg::jump_t    jump_o,
    output ex_pkg::mem_req_t mem_o
);
    import rv_isa_pkg::*;
    import ex_pkg::*;

    xlen_t   target;   // shared by jumps and memory
    funct3_t funct3;
    logic    taken;

    assign target = req_i.base_addr + req_i.offset_addr;
    assign funct3 = req_i.inst[14:12];

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq_i;
            F3_BNE:  taken = ~eq_i;
            F3_BLT:  taken = lt_i;
            F3_BGE:  taken = ~lt_i;
            F3_BLTU: taken = ltu_i;
            F3_BGEU: taken = ~ltu_i;
            default: taken = 1'b0;   // 010 / 011 not a branch
        endcase
    end

    always_comb begin
        jump_o = '0;
        if (dec_i.is_jump) begin
            jump_o.en   = 1'b1;
            jump_o.addr = target;
        end else if (dec_i.is_branch) begin
            jump_o.en   = taken;
            jump_o.addr = target;
        end
    end

    always_comb begin
        mem_o = '0;
        if (dec_i.is_load) begin
            mem_o.ren  = 1'b1;
            mem_o.addr = target;
            mem_o.size = dec_i.mem_size;
        end else if (dec_i.is_store) begin
            mem_o.wen  = 1'b1;
            mem_o.addr = target;
            mem_o.size = dec_i.mem_size;
            case (dec_i.mem_size)
                F3_SB: begin
                    mem_o.wdata = {{(XLEN-8){1'b0}}, req_i.op2[7:0]};
                    mem_o.wmask = 8'h01;
                end
                F3_SH: begin
                    mem_o.wdata = {{(XLEN-16){1'b0}}, req_i.op2[15:0]};
                    mem_o.wmask = 8'h03;
                end
                F3_SW: begin
                    mem_o.wdata = {{(XLEN-32){1'b0}}, req_i.op2[31:0]};
                    mem_o.wmask = 8'h0f;
                end
                default: begin   // sd
                    mem_o.wdata = req_i.op2;
                    mem_o.wmask = 8'hff;
                end
            endcase
        end
    end

endmodule

/* ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::xlen_t     pc_i,
    input  rv_isa_pkg::reg_addr_t rd_addr_i,
    input  ex_pkg::dec_t          dec_i,
    input  rv_isa_pkg::xlen_t     alu_result_i,
    input  ex_pkg::jump_t         jump_i,
    input  ex_pkg::mem_req_t      mem_i,
    output ex_pkg::wb_t           wb_o,
    output ex_pkg::mem_req_t      mem_o,
    output ex_pkg::jump_t         jump_o,
    output rv_isa_pkg::xlen_t     pc_o
);
    import ex_pkg::*;

    wb_t wb_d;

    // result select
    always_comb begin
        wb_d.wen   = dec_i.rd_wen;
        wb_d.waddr = rd_addr_i;
        wb_d.wdata = dec_i.is_load ? '0 : alu_result_i;  // load data comes from mem stage
    end

    // ex/mem boundary
    always_ff @(posedge clk) begin
        wb_o   <= wb_d;
        mem_o  <= mem_i;
        jump_o <= jump_i;
        pc_o   <= pc_i;
        if (!rst_n_i) begin
            // only the enables and mask are cleared, payload just flows
            wb_o.wen    <= 1'b0;
            mem_o.ren   <= 1'b0;
            mem_o.wen   <= 1'b0;
            mem_o.wmask <= '0;
            jump_o.en   <= 1'b0;
        end
    end

endmodule

/* ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ex_pkg::ex_req_t   ex_req_i,
    output ex_pkg::wb_t       wb_o,
    output ex_pkg::mem_req_t  mem_o,
    output ex_pkg::jump_t     jump_o,
    output rv_isa_pkg::xlen_t pc_o
);
    import rv_isa_pkg::*;
    import ex_pkg::*;

    dec_t     dec;
    xlen_t    alu_result;
    logic     alu_eq;
    logic     alu_lt;
    logic     alu_ltu;
    jump_t    jump_c;   // combinational, before the boundary
    mem_req_t mem_c;

    ex_decode u_decode (
        .inst_i (ex_req_i.inst),
        .dec_o  (dec)
    );

    ex_alu u_alu (
        .op1_i     (ex_req_i.op1),
        .op2_i     (ex_req_i.op2),
        .alu_op_i  (dec.alu_op),
        .word_op_i (dec.word_op),
        .result_o  (alu_result),
        .eq_o      (alu_eq),
        .lt_o      (alu_lt),
        .ltu_o     (alu_ltu)
    );

    ex_addr_unit u_addr_unit (
        .req_i  (ex_req_i),
        .dec_i  (dec),
        .eq_i   (alu_eq),
        .lt_i   (alu_lt),
        .ltu_i  (alu_ltu),
        .jump_o (jump_c),
        .mem_o  (mem_c)
    );

    ex_mem_reg u_mem_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (ex_req_i.pc),
        .rd_addr_i    (ex_req_i.rd_addr),
        .dec_i        (dec),
        .alu_result_i (alu_result),
        .jump_i       (jump_c),
        .mem_i        (mem_c),
        .wb_o         (wb_o),
        .mem_o        (mem_o),
        .jump_o       (jump_o),
        .pc_o         (pc_o)
    );

endmodule

/* ex_properties.sv */
`timescale 1ns/1ps

module ex_properties (
    input logic             clk,
    input logic             rst_n_i,
    input ex_pkg::wb_t      wb_i,
    input ex_pkg::mem_req_t mem_i,
    input ex_pkg::jump_t    jump_i
);

    // a request is a read or a write, never both
    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_i.ren && mem_i.wen))
        else $error("memory read and write enables high together");

    a_mask_with_wen: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_i.wmask != '0) == mem_i.wen)   // mask only on stores
        else $error("byte mask does not follow the write enable");

    // reset edge leaves every enable low
    a_reset_clears: assert property (@(posedge clk)
        !rst_n_i |=> !(wb_i.wen || mem_i.ren || mem_i.wen || jump_i.en))
        else $error("an enable is still high after a reset cycle");

endmodule

bind ex_mem_reg ex_properties u_properties (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wb_i    (wb_o),
    .mem_i   (mem_o),
    .jump_i  (jump_o)
);

/* tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;
    import rv_isa_pkg::*;
    import ex_pkg::*;

    logic     clk;
    logic     rst_n_i;
    ex_req_t  ex_req;
    wb_t      wb;
    mem_req_t mem;
    jump_t    jump;
    xlen_t    pc;

    integer   seed;
    int       errors;
    int       checks;
    int       waited;
    xlen_t    next_pc;
    ex_req_t  cur_req;   // last request driven

    ex_top u_dut (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_req_i (ex_req),
        .wb_o     (wb),
        .mem_o    (mem),
        .jump_o   (jump),
        .pc_o     (pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for three edges
    initial begin
        rst_n_i     = 1'b0;
        ex_req      = '0;
        ex_req.inst = encode(JAL, 3'd0, F7_BASE);   // a jump held in reset must not show
        repeat (3) @(posedge clk);
        #1 rst_n_i = 1'b1;
    end

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic inst_t encode(input opcode_t opc, input funct3_t f3, input funct7_t f7);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    // rv64i semantics with the word forms sign-extended from bit 31
    function automatic xlen_t alu_model(input funct3_t f3, input logic alt, input logic is_imm,
                                        input logic word, input xlen_t a, input xlen_t b);
        logic        sub;
        logic [31:0] w;
        xlen_t       r;
        sub = alt && (!is_imm || f3 == F3_SR);   // there is no subi
        if (word) begin
            case (f3)
                F3_SLL: w = a[31:0] << b[4:0];
                F3_SR: begin
                    if (sub)
                        w = $signed(a[31:0]) >>> b[4:0];
                    else
                        w = a[31:0] >> b[4:0];
                end
                default: w = sub ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            endcase
            r = {{32{w[31]}}, w};
        end else begin
            case (f3)
                F3_ADD_SUB: r = sub ? a - b : a + b;
                F3_SLL:     r = a << b[5:0];
                F3_SLT:     r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                F3_SLTU:    r = (a < b) ? 64'd1 : 64'd0;
                F3_XOR:     r = a ^ b;
                F3_SR: begin
                    if (sub)
                        r = $signed(a) >>> b[5:0];
                    else
                        r = a >> b[5:0];
                end
                F3_OR:      r = a | b;
                default:    r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic wb_t wb_exp(input logic wen, input reg_addr_t rd, input xlen_t data);
        wb_t e;
        e.wen   = wen;
        e.waddr = rd;
        e.wdata = data;
        return e;
    endfunction

    function automatic mem_req_t mem_exp(input logic ren, input logic wen, input xlen_t addr,
                                         input xlen_t data, input funct3_t f3);
        mem_req_t e;
        e       = '0;
        e.ren   = ren;
        e.wen   = wen;
        e.addr  = addr;
        e.size  = f3;
        e.wdata = data;
        if (wen)
            e.wmask = wmask_t'((9'd1 << (1 << f3)) - 9'd1);   // 1, 2, 4 or 8 lanes
        return e;
    endfunction

    function automatic jump_t jump_exp(input logic en, input xlen_t addr);
        jump_t e;
        e.en   = en;
        e.addr = addr;
        return e;
    endfunction

    task automatic compare_val(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // drive after the edge and sample well after the next one
    task automatic issue(input inst_t inst, input xlen_t a, input xlen_t b, input reg_addr_t rd,
                         input xlen_t base, input xlen_t off);
        @(posedge clk);
        #1;
        cur_req.inst        = inst;
        cur_req.pc          = next_pc;
        cur_req.op1         = a;
        cur_req.op2         = b;
        cur_req.rd_addr     = rd;
        cur_req.base_addr   = base;
        cur_req.offset_addr = off;
        ex_req  = cur_req;
        next_pc = next_pc + 64'd4;
        @(posedge clk);
        #10;
    endtask

    task automatic check_outputs(input string tag, input wb_t ew, input mem_req_t em,
                                 input jump_t ej);
        compare_val({tag, " wb.wen"}, wb.wen, ew.wen);
        if (ew.wen) begin
            compare_val({tag, " wb.waddr"}, wb.waddr, ew.waddr);
            compare_val({tag, " wb.wdata"}, wb.wdata, ew.wdata);
        end
        compare_val({tag, " mem.ren"}, mem.ren, em.ren);
        compare_val({tag, " mem.wen"}, mem.wen, em.wen);
        compare_val({tag, " mem.addr"}, mem.addr, em.addr);
        compare_val({tag, " mem.wdata"}, mem.wdata, em.wdata);
        compare_val({tag, " mem.wmask"}, mem.wmask, em.wmask);
        compare_val({tag, " mem.size"}, mem.size, em.size);
        compare_val({tag, " jump.en"}, jump.en, ej.en);
        compare_val({tag, " jump.addr"}, jump.addr, ej.addr);
        compare_val({tag, " pc"}, pc, cur_req.pc);
    endtask

    task automatic reset_state();
        compare_val("reset wb.wen", wb.wen, 0);
        compare_val("reset mem.ren", mem.ren, 0);
        compare_val("reset mem.wen", mem.wen, 0);
        compare_val("reset jump.en", jump.en, 0);
    endtask

    task automatic alu_rv64_ops();
        xlen_t   a;
        xlen_t   b;
        xlen_t   imm;
        funct3_t f3;
        for (int i = 0; i < 8; i++) begin
            for (int n = 0; n < 4; n++) begin
                f3 = funct3_t'(i);
                a  = rand64();
                b  = rand64();
                issue(encode(OP, f3, F7_BASE), a, b, 5'd7, 0, 0);
                check_outputs($sformatf("op f3=%0d", f3),
                              wb_exp(1'b1, 5'd7, alu_model(f3, 1'b0, 1'b0, 1'b0, a, b)),
                              '0, '0);
                if (f3 == F3_ADD_SUB || f3 == F3_SR) begin   // sub, sra
                    issue(encode(OP, f3, F7_ALT), a, b, 5'd8, 0, 0);
                    check_outputs($sformatf("op alt f3=%0d", f3),
                                  wb_exp(1'b1, 5'd8, alu_model(f3, 1'b1, 1'b0, 1'b0, a, b)),
                                  '0, '0);
                end
                imm = rand64();
                if (f3 == F3_SLL || f3 == F3_SR)
                    b = {58'd0, imm[5:0]};
                else
                    b = {{52{imm[11]}}, imm[11:0]};
                issue(encode(OP_IMM, f3, (f3 == F3_SR && n[0]) ? F7_ALT : F7_BASE),
                      a, b, 5'd9, 0, 0);
                check_outputs($sformatf("op_imm f3=%0d", f3),
                              wb_exp(1'b1, 5'd9, alu_model(f3, n[0], 1'b1, 1'b0, a, b)),
                              '0, '0);
            end
        end
        issue(encode(OP, F3_ADD_SUB, 7'b0000001), a, b, 5'd7, 0, 0);   // mul encoding
        check_outputs("op bad func7", wb_exp(1'b0, 5'd7, 0), '0, '0);
    endtask

    task automatic word_ops();
        xlen_t   a;
        xlen_t   b;
        opcode_t opc;
        funct3_t f3;
        logic    alt;
        for (int n = 0; n < 3; n++) begin
            a = rand64() | 64'h0000_0000_8000_0000;
            b = rand64() | 64'h0000_0000_8000_0020;   // op2[5] set but ignored by word shifts
            for (int k = 0; k < 10; k++) begin
                opc = (k < 5) ? OP_32 : OP_IMM_32;
                f3  = (k % 5 < 2) ? F3_ADD_SUB : ((k % 5 == 2) ? F3_SLL : F3_SR);
                alt = (k % 5 == 1) || (k % 5 == 4);
                issue(encode(opc, f3, alt ? F7_ALT : F7_BASE), a, b, 5'd11, 0, 0);
                check_outputs($sformatf("word k=%0d", k),
                              wb_exp(1'b1, 5'd11, alu_model(f3, alt, k >= 5, 1'b1, a, b)),
                              '0, '0);
            end
        end
    endtask

    task automatic branch_ops();
        xlen_t   pa [5];
        xlen_t   pb [5];
        funct3_t bf3 [6];
        xlen_t   base;
        xlen_t   off;
        pa  = '{64'd5, 64'hffff_ffff_ffff_ffff, 64'd1, 64'h8000_0000_0000_0000, 64'd3};
        pb  = '{64'd5, 64'd1, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 64'd7};
        bf3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 5; p++) begin
                base = rand64();
                off  = {{51{base[12]}}, base[12:1], 1'b0};   // even offset
                issue(encode(BRANCH, bf3[i], F7_BASE), pa[p], pb[p], 5'd0, base, off);
                check_outputs($sformatf("branch f3=%0d pair %0d", bf3[i], p),
                              wb_exp(1'b0, 5'd0, 0), '0,
                              jump_exp(branch_taken(bf3[i], pa[p], pb[p]), base + off));
            end
        end
    endtask

    task automatic load_store_ops();
        xlen_t base;
        xlen_t off;
        xlen_t data;
        xlen_t keep;
        for (int i = 0; i < 7; i++) begin
            base = rand64();
            off  = {{52{base[11]}}, base[11:0]};
            issue(encode(LOAD, funct3_t'(i), F7_BASE), rand64(), rand64(), 5'd12, base, off);
            check_outputs($sformatf("load f3=%0d", i), wb_exp(1'b1, 5'd12, 0),
                          mem_exp(1'b1, 1'b0, base + off, 0, funct3_t'(i)), '0);
        end
        for (int i = 0; i < 4; i++) begin
            base = rand64();
            off  = {{52{base[11]}}, base[11:0]};
            data = rand64();
            keep = (i == 3) ? '1 : ((64'd1 << (8 << i)) - 64'd1);
            issue(encode(STORE, funct3_t'(i), F7_BASE), 0, data, 5'd0, base, off);
            check_outputs($sformatf("store f3=%0d", i), wb_exp(1'b0, 5'd0, 0),
                          mem_exp(1'b0, 1'b1, base + off, data & keep, funct3_t'(i)), '0);
        end
    endtask

    task automatic upper_jump_ops();
        xlen_t a;
        xlen_t b;
        xlen_t base;
        a    = rand64();
        b    = rand64() & 64'hffff_ffff_ffff_f000;
        base = rand64();
        issue(encode(LUI, 3'd0, F7_BASE), a, b, 5'd13, 0, 0);
        check_outputs("lui", wb_exp(1'b1, 5'd13, b), '0, '0);
        issue(encode(AUIPC, 3'd0, F7_BASE), a, b, 5'd14, base, 64'd8);
        check_outputs("auipc", wb_exp(1'b1, 5'd14, a + b), '0, '0);
        issue(encode(JAL, 3'd0, F7_BASE), a, 64'd4, 5'd1, base, 64'h0000_0000_0000_0800);
        check_outputs("jal", wb_exp(1'b1, 5'd1, a + 64'd4), '0,
                      jump_exp(1'b1, base + 64'h0000_0000_0000_0800));
        issue(encode(JALR, 3'd0, F7_BASE), a, 64'd4, 5'd5, base, 64'hffff_ffff_ffff_fff0);
        check_outputs("jalr", wb_exp(1'b1, 5'd5, a + 64'd4), '0,
                      jump_exp(1'b1, base + 64'hffff_ffff_ffff_fff0));
        issue(encode(7'b1111111, 3'd0, F7_BASE), a, b, 5'd6, base, 64'd4);
        check_outputs("bad opcode", wb_exp(1'b0, 5'd6, 0), '0, '0);
    endtask

    initial begin
        seed    = 32'h9d06;
        errors  = 0;
        checks  = 0;
        next_pc = 64'h0000_0000_8000_0000;
        cur_req = '0;
        waited  = 0;
        while (rst_n_i !== 1'b1 && waited < 1000) begin
            #1;
            waited++;
        end
        if (rst_n_i !== 1'b1) begin
            $display("reset was not released within 1000 ns");
            $display("Testbench failed");
            $finish;
        end else begin
            #1;
            reset_state();
            alu_rv64_ops();
            word_ops();
            branch_ops();
            load_store_ops();
            upper_jump_ops();
            $display("checks: %0d  errors: %0d", checks, errors);
            if (errors == 0)
                $display("Testbench passed");
            else
                $display("Testbench failed");
            $finish;
        end
    end

endmodule

/* tb.f */
rv_isa_pkg.sv
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_addr_unit.sv
ex_mem_reg.sv
ex_top.sv
ex_properties.sv
tb_ex_top.sv
